//--- logic/download_decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "loader_settings.svh"

module download_decoder (
	input  wire                        clk_sys,
	input  wire                        reset_n,
	input  wire                        dl_active_i,
	input  wire loader_pkg::file_idx_t dl_index_i,
	input  wire loader_pkg::mem_addr_t dl_addr_i,
	input  wire loader_pkg::mem_byte_t dl_data_i,
	input  wire                        dl_wr_i,
	output logic                       dl_wait_o,
	output logic                       wr_req_o,
	output loader_pkg::mem_req_t       wr_o,
	input  wire                        wr_ack_i,
	output loader_pkg::mem_addr_t      tape_len_o,
	output logic                       tape_loaded_o
);

	logic                  is_prg;
	logic                  is_tap;
	logic                  data_wr;
	logic                  active_q;
	logic                  ack_seen;
	loader_pkg::mem_addr_t load_addr;
	loader_pkg::mem_addr_t tap_cnt;

	assign is_prg  = (dl_index_i == `LDR_IDX_PRG);
	assign is_tap  = (dl_index_i == `LDR_IDX_TAP);
	// Header bytes 0 and 1 of a PRG only set the load address
	assign data_wr = dl_wr_i &&
		(is_tap || (is_prg && (dl_addr_i > loader_pkg::mem_addr_t'(1))));

	// ======================================================================
	// Load address and write payload
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (dl_wr_i && is_prg && (dl_addr_i == '0)) begin
			load_addr <= loader_pkg::mem_addr_t'(dl_data_i);
		end else if (dl_wr_i && is_prg && (dl_addr_i == loader_pkg::mem_addr_t'(1))) begin
			load_addr[15:8] <= dl_data_i;
		end else if (data_wr && is_prg) begin
			wr_o      <= '{we: 1'b1, addr: load_addr, data: dl_data_i};
			load_addr <= load_addr + 1'b1;
		end else if (data_wr) begin
			wr_o <= '{we: 1'b1, addr: `LDR_TAP_BASE + dl_addr_i, data: dl_data_i};
		end
	end

	// ======================================================================
	// Request handshake, host wait and tape length
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			dl_wait_o     <= 1'b0;
			wr_req_o      <= 1'b0;
			ack_seen      <= 1'b0;
			active_q      <= 1'b0;
			tap_cnt       <= '0;
			tape_len_o    <= '0;
			tape_loaded_o <= 1'b0;
		end else begin
			active_q      <= dl_active_i;
			tape_loaded_o <= 1'b0;

			if (data_wr) begin
				wr_req_o  <= 1'b1;
				dl_wait_o <= 1'b1;
			end

			// Byte count of the tape so far
			if (dl_active_i && !active_q) begin
				tap_cnt <= '0;
			end else if (dl_wr_i && is_tap) begin
				tap_cnt <= dl_addr_i + 1'b1;
			end

			if (wr_req_o && wr_ack_i) begin
				wr_req_o <= 1'b0;
				ack_seen <= 1'b1;
			end

			// Host may go on once the memory cycle has fully closed
			if (ack_seen && !wr_ack_i) begin
				ack_seen  <= 1'b0;
				dl_wait_o <= 1'b0;
			end

			if (!dl_active_i && active_q && is_tap) begin
				tape_len_o    <= tap_cnt;
				tape_loaded_o <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/loader_pkg.sv
`default_nettype none
`include "loader_settings.svh"

package loader_pkg;

	// Vector types for the memory side
	typedef logic [`LDR_ADDR_W-1:0] mem_addr_t;
	typedef logic [7:0]             mem_byte_t;
	typedef logic [7:0]             file_idx_t;

	// One memory request, held stable while its req is high
	typedef struct packed {
		logic      we;
		mem_addr_t addr;
		mem_byte_t data;
	} mem_req_t;

	// Arbiter grant state
	typedef enum logic [1:0] {
		GRANT_IDLE,
		GRANT_LOADER,
		GRANT_TAPE
	} grant_e;

	// Tape fetcher state
	typedef enum logic [1:0] {
		FETCH_IDLE,
		FETCH_REQUEST,
		FETCH_WAIT_RELEASE
	} fetch_e;

endpackage

`default_nettype wire

//--- logic/loader_settings.svh
`ifndef LOADER_SETTINGS_SVH
`define LOADER_SETTINGS_SVH

// ======================================================================
// Download and tape path settings
// ======================================================================

// Byte address width of the shared memory
`define LDR_ADDR_W 25

// Tape image lives at a fixed offset in shared memory
`define LDR_TAP_BASE 25'h200000

// Tape FIFO entries, a power of two
`define LDR_FIFO_DEPTH 8

// Host file index codes
`define LDR_IDX_PRG 8'd4
`define LDR_IDX_TAP 8'd6

`endif

//--- logic/loader_top.sv
`timescale 1ns/1ps
`default_nettype none

module loader_top (
	input  wire                        clk_sys,
	input  wire                        reset_n,
	// Host download stream
	input  wire                        dl_active_i,
	input  wire loader_pkg::file_idx_t dl_index_i,
	input  wire loader_pkg::mem_addr_t dl_addr_i,
	input  wire loader_pkg::mem_byte_t dl_data_i,
	input  wire                        dl_wr_i,
	output logic                       dl_wait_o,
	// External memory
	output logic                       mem_req_o,
	output loader_pkg::mem_req_t       mem_o,
	input  wire                        mem_ack_i,
	input  wire loader_pkg::mem_byte_t mem_rdata_i,
	// Tape control and byte stream
	input  wire                        play_btn_i,
	output logic                       tape_req_o,
	output loader_pkg::mem_byte_t      tape_byte_o,
	input  wire                        tape_ack_i,
	output logic                       tape_done_o
);

	logic                  ld_req;
	loader_pkg::mem_req_t  ld_bus;
	logic                  ld_ack;
	logic                  tp_req;
	loader_pkg::mem_req_t  tp_bus;
	logic                  tp_ack;
	loader_pkg::mem_byte_t tp_rdata;
	loader_pkg::mem_addr_t tape_len;
	logic                  tape_loaded;
	logic                  push;
	loader_pkg::mem_byte_t push_data;
	logic                  fifo_full;
	logic                  fifo_empty;
	loader_pkg::mem_byte_t fifo_head;
	logic                  fifo_pop;
	logic                  fifo_rst_n;
	logic                  out_busy;
	logic                  play;
	logic                  ack_q;

	// FIFO also flushes when a new tape image lands
	assign fifo_rst_n = reset_n && !tape_loaded;

	download_decoder u_decoder (
		.clk_sys       (clk_sys),
		.reset_n       (reset_n),
		.dl_active_i   (dl_active_i),
		.dl_index_i    (dl_index_i),
		.dl_addr_i     (dl_addr_i),
		.dl_data_i     (dl_data_i),
		.dl_wr_i       (dl_wr_i),
		.dl_wait_o     (dl_wait_o),
		.wr_req_o      (ld_req),
		.wr_o          (ld_bus),
		.wr_ack_i      (ld_ack),
		.tape_len_o    (tape_len),
		.tape_loaded_o (tape_loaded)
	);

	mem_arbiter u_arbiter (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.ld_req_i    (ld_req),
		.ld_i        (ld_bus),
		.ld_ack_o    (ld_ack),
		.tp_req_i    (tp_req),
		.tp_i        (tp_bus),
		.tp_ack_o    (tp_ack),
		.rd_data_o   (tp_rdata),
		.mem_req_o   (mem_req_o),
		.mem_o       (mem_o),
		.mem_ack_i   (mem_ack_i),
		.mem_rdata_i (mem_rdata_i)
	);

	tape_fetcher u_fetcher (
		.clk_sys       (clk_sys),
		.reset_n       (reset_n),
		.tape_len_i    (tape_len),
		.tape_loaded_i (tape_loaded),
		.play_btn_i    (play_btn_i),
		.rd_req_o      (tp_req),
		.rd_o          (tp_bus),
		.rd_ack_i      (tp_ack),
		.rd_data_i     (tp_rdata),
		.push_o        (push),
		.push_data_o   (push_data),
		.fifo_full_i   (fifo_full),
		.fifo_empty_i  (fifo_empty),
		.out_busy_i    (out_busy),
		.play_o        (play),
		.tape_done_o   (tape_done_o)
	);

	tape_fifo u_fifo (
		.clk_sys     (clk_sys),
		.reset_n     (fifo_rst_n),
		.push_i      (push),
		.push_data_i (push_data),
		.pop_i       (fifo_pop),
		.head_o      (fifo_head),
		.full_o      (fifo_full),
		.empty_o     (fifo_empty)
	);

	// ======================================================================
	// Tape output handshake
	// ======================================================================
	assign fifo_pop = tape_req_o && tape_ack_i && !ack_q;
	assign out_busy = tape_req_o || tape_ack_i;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			tape_req_o <= 1'b0;
			ack_q      <= 1'b0;
		end else begin
			ack_q <= tape_ack_i;
			if (tape_req_o) begin
				if (tape_ack_i) begin
					tape_req_o <= 1'b0;
				end
			end else if (!tape_ack_i && play && !fifo_empty) begin
				// Pause only blocks the next handshake
				tape_req_o <= 1'b1;
			end
		end
	end

	// Byte is captured with the rising req and held until the next one
	always_ff @(posedge clk_sys) begin
		if (!tape_req_o && !tape_ack_i) begin
			tape_byte_o <= fifo_head;
		end
	end

endmodule

`default_nettype wire

//--- logic/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
	input  wire                        clk_sys,
	input  wire                        reset_n,
	// Loader side, write only
	input  wire                        ld_req_i,
	input  wire loader_pkg::mem_req_t  ld_i,
	output logic                       ld_ack_o,
	// Tape fetcher side, read only
	input  wire                        tp_req_i,
	input  wire loader_pkg::mem_req_t  tp_i,
	output logic                       tp_ack_o,
	output loader_pkg::mem_byte_t      rd_data_o,
	// External memory port
	output logic                       mem_req_o,
	output loader_pkg::mem_req_t       mem_o,
	input  wire                        mem_ack_i,
	input  wire loader_pkg::mem_byte_t mem_rdata_i
);

	loader_pkg::grant_e state;
	logic               ack_seen;

	// ======================================================================
	// Grant FSM
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			state    <= loader_pkg::GRANT_IDLE;
			ack_seen <= 1'b0;
		end else begin
			case (state)
				loader_pkg::GRANT_IDLE: begin
					ack_seen <= 1'b0;
					// Loader wins a tie
					if (ld_req_i) begin
						state <= loader_pkg::GRANT_LOADER;
					end else if (tp_req_i) begin
						state <= loader_pkg::GRANT_TAPE;
					end
				end
				default: begin
					// Hold the grant until the outside ack has come and gone
					if (mem_ack_i) begin
						ack_seen <= 1'b1;
					end else if (ack_seen) begin
						ack_seen <= 1'b0;
						state    <= loader_pkg::GRANT_IDLE;
					end
				end
			endcase
		end
	end

	// Forward the granted request, route ack and data back to it only
	always_comb begin
		mem_req_o = 1'b0;
		mem_o     = '0;
		ld_ack_o  = 1'b0;
		tp_ack_o  = 1'b0;
		rd_data_o = '0;
		case (state)
			loader_pkg::GRANT_LOADER: begin
				mem_req_o = ld_req_i;
				mem_o     = ld_i;
				ld_ack_o  = mem_ack_i;
			end
			loader_pkg::GRANT_TAPE: begin
				mem_req_o = tp_req_i;
				mem_o     = tp_i;
				tp_ack_o  = mem_ack_i;
				rd_data_o = mem_rdata_i;
			end
			default: begin
				mem_req_o = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- logic/tape_fetcher.sv
`timescale 1ns/1ps
`default_nettype none
`include "loader_settings.svh"

module tape_fetcher (
	input  wire                        clk_sys,
	input  wire                        reset_n,
	input  wire loader_pkg::mem_addr_t tape_len_i,
	input  wire                        tape_loaded_i,
	input  wire                        play_btn_i,
	output logic                       rd_req_o,
	output loader_pkg::mem_req_t       rd_o,
	input  wire                        rd_ack_i,
	input  wire loader_pkg::mem_byte_t rd_data_i,
	output logic                       push_o,
	output loader_pkg::mem_byte_t      push_data_o,
	input  wire                        fifo_full_i,
	input  wire                        fifo_empty_i,
	input  wire                        out_busy_i,
	output logic                       play_o,
	output logic                       tape_done_o
);

	loader_pkg::fetch_e    state;
	loader_pkg::mem_addr_t fetch_cnt;
	loader_pkg::mem_addr_t fetch_addr;
	logic                  discard;
	logic                  btn_q;

	assign rd_o = '{we: 1'b0, addr: fetch_addr, data: '0};

	// Everything fetched, delivered and no output handshake open
	assign tape_done_o = (tape_len_i != '0) && (fetch_cnt == tape_len_i) &&
		fifo_empty_i && !push_o && !out_busy_i;

	// Address follows the count while idle, frozen during a read
	always_ff @(posedge clk_sys) begin
		if (state == loader_pkg::FETCH_IDLE) begin
			fetch_addr <= `LDR_TAP_BASE + fetch_cnt;
		end
		if (state == loader_pkg::FETCH_REQUEST && rd_ack_i) begin
			push_data_o <= rd_data_i;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			state     <= loader_pkg::FETCH_IDLE;
			rd_req_o  <= 1'b0;
			push_o    <= 1'b0;
			fetch_cnt <= '0;
			discard   <= 1'b0;
			btn_q     <= 1'b0;
			play_o    <= 1'b0;
		end else begin
			push_o <= 1'b0;
			btn_q  <= play_btn_i;
			if (play_btn_i && !btn_q) begin
				play_o <= !play_o;
			end

			case (state)
				loader_pkg::FETCH_IDLE: begin
					if (!tape_loaded_i && !fifo_full_i && (fetch_cnt < tape_len_i)) begin
						rd_req_o <= 1'b1;
						state    <= loader_pkg::FETCH_REQUEST;
					end
				end
				loader_pkg::FETCH_REQUEST: begin
					if (rd_ack_i) begin
						rd_req_o <= 1'b0;
						state    <= loader_pkg::FETCH_WAIT_RELEASE;
						if (!discard && !tape_loaded_i) begin
							push_o    <= 1'b1;
							fetch_cnt <= fetch_cnt + 1'b1;
						end
					end
				end
				default: begin
					if (!rd_ack_i) begin
						discard <= 1'b0;
						state   <= loader_pkg::FETCH_IDLE;
					end
				end
			endcase

			// New tape restarts from byte 0, a read in flight is dropped
			if (tape_loaded_i) begin
				play_o    <= 1'b1;
				fetch_cnt <= '0;
				if (state != loader_pkg::FETCH_IDLE) begin
					discard <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/tape_fifo.sv
`timescale 1ns/1ps
`default_nettype none
`include "loader_settings.svh"

module tape_fifo (
	input  wire                        clk_sys,
	input  wire                        reset_n,
	input  wire                        push_i,
	input  wire loader_pkg::mem_byte_t push_data_i,
	input  wire                        pop_i,
	output loader_pkg::mem_byte_t      head_o,
	output logic                       full_o,
	output logic                       empty_o
);

	localparam int PTR_W = $clog2(`LDR_FIFO_DEPTH);

	loader_pkg::mem_byte_t buf_q [`LDR_FIFO_DEPTH];
	logic [PTR_W-1:0]      rd_ptr;
	logic [PTR_W-1:0]      wr_ptr;
	logic [PTR_W:0]        count;
	logic                  do_push;
	logic                  do_pop;

	assign full_o  = (count == (PTR_W + 1)'(`LDR_FIFO_DEPTH));
	assign empty_o = (count == '0);
	assign do_push = push_i && !full_o;
	assign do_pop  = pop_i && !empty_o;
	assign head_o  = buf_q[rd_ptr];

	always_ff @(posedge clk_sys) begin
		if (do_push) begin
			buf_q[wr_ptr] <= push_data_i;
		end
	end

	// Pointers wrap on their own since the depth is a power of two
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count <= count + do_push - do_pop;
		end
	end

endmodule

`default_nettype wire

//--- tb.f
+incdir+logic
logic/loader_pkg.sv
logic/download_decoder.sv
logic/mem_arbiter.sv
logic/tape_fetcher.sv
logic/tape_fifo.sv
logic/loader_top.sv
verification/loader_properties.sv
verification/loader_tb.sv

//--- verification/loader_properties.sv
`timescale 1ns/1ps
`default_nettype none

module loader_properties (
	input wire                       clk_sys,
	input wire                       reset_n,
	input wire                       mem_req_i,
	input wire loader_pkg::mem_req_t mem_bus_i,
	input wire                       mem_ack_i,
	input wire                       tape_req_i,
	input wire                       tape_ack_i,
	input wire                       play_i
);

	// Number of assertion failures so far
	int unsigned fail_cnt = 0;

	// Payload held for the whole memory cycle
	mem_bus_stable: assert property (@(posedge clk_sys) disable iff (!reset_n)
		mem_req_i && $past(mem_req_i) |-> $stable(mem_bus_i))
		else begin
			fail_cnt++;
			$error("mem_o changed while mem_req_o was high");
		end

	// Four-phase rule, a new req waits for the old ack to fall
	mem_req_rise: assert property (@(posedge clk_sys) disable iff (!reset_n)
		$rose(mem_req_i) |-> !mem_ack_i)
		else begin
			fail_cnt++;
			$error("mem_req_o rose while mem_ack_i was high");
		end

	tape_req_rise: assert property (@(posedge clk_sys) disable iff (!reset_n)
		$rose(tape_req_i) |-> !tape_ack_i)
		else begin
			fail_cnt++;
			$error("tape_req_o rose while tape_ack_i was high");
		end

	// Paused tape starts no output handshake
	tape_req_play: assert property (@(posedge clk_sys) disable iff (!reset_n)
		$rose(tape_req_i) |-> $past(play_i))
		else begin
			fail_cnt++;
			$error("tape_req_o rose while play was low");
		end

endmodule

bind loader_top loader_properties props (
	.clk_sys    (clk_sys),
	.reset_n    (reset_n),
	.mem_req_i  (mem_req_o),
	.mem_bus_i  (mem_o),
	.mem_ack_i  (mem_ack_i),
	.tape_req_i (tape_req_o),
	.tape_ack_i (tape_ack_i),
	.play_i     (play)
);

`default_nettype wire

//--- verification/loader_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "loader_settings.svh"

module loader_tb;

	// Each row holds the kind, PRG header address, payload length and pause point
	typedef struct packed {
		logic        is_tap;
		logic [7:0]  addr_lo;
		logic [7:0]  addr_hi;
		logic [15:0] len;
		logic [15:0] pause_at;
	} stim_t;

	localparam int NUM_LOADS = 4;
	localparam stim_t STIM_TABLE [NUM_LOADS] = '{
		'{is_tap: 1'b0, addr_lo: 8'h01, addr_hi: 8'h08, len: 16'd24, pause_at: 16'd0},
		'{is_tap: 1'b1, addr_lo: 8'h00, addr_hi: 8'h00, len: 16'd64, pause_at: 16'd8},
		'{is_tap: 1'b0, addr_lo: 8'h00, addr_hi: 8'hc0, len: 16'd32, pause_at: 16'd0},
		'{is_tap: 1'b0, addr_lo: 8'hf8, addr_hi: 8'hff, len: 16'd12, pause_at: 16'd0}
	};

	logic                  clk_sys = 1'b0;
	logic                  reset_n;
	logic                  dl_active;
	loader_pkg::file_idx_t dl_index;
	loader_pkg::mem_addr_t dl_addr;
	loader_pkg::mem_byte_t dl_data;
	logic                  dl_wr;
	logic                  dl_wait;
	logic                  mem_req;
	loader_pkg::mem_req_t  mem_bus;
	logic                  mem_ack;
	loader_pkg::mem_byte_t mem_rdata;
	logic                  play_btn;
	logic                  tape_req;
	loader_pkg::mem_byte_t tape_byte;
	logic                  tape_ack;
	logic                  tape_done;

	loader_pkg::mem_byte_t mem [loader_pkg::mem_addr_t];
	loader_pkg::mem_byte_t exp_mem [loader_pkg::mem_addr_t];
	loader_pkg::mem_req_t  wr_log [$];
	loader_pkg::mem_req_t  exp_wr [$];
	loader_pkg::mem_byte_t file_bytes [$];
	loader_pkg::mem_byte_t exp_tape [$];
	loader_pkg::mem_byte_t got_tape [$];
	int unsigned           errors = 0;
	int unsigned           checks = 0;

	always #5 clk_sys = ~clk_sys;

	loader_top dut (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.dl_active_i (dl_active),
		.dl_index_i  (dl_index),
		.dl_addr_i   (dl_addr),
		.dl_data_i   (dl_data),
		.dl_wr_i     (dl_wr),
		.dl_wait_o   (dl_wait),
		.mem_req_o   (mem_req),
		.mem_o       (mem_bus),
		.mem_ack_i   (mem_ack),
		.mem_rdata_i (mem_rdata),
		.play_btn_i  (play_btn),
		.tape_req_o  (tape_req),
		.tape_byte_o (tape_byte),
		.tape_ack_i  (tape_ack),
		.tape_done_o (tape_done)
	);

	// ======================================================================
	// Compare tasks
	// ======================================================================
	task automatic check_addr(input string name, input loader_pkg::mem_addr_t got,
		input loader_pkg::mem_addr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_byte(input string name, input loader_pkg::mem_byte_t got,
		input loader_pkg::mem_byte_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h expected %h", name, got, exp);
		end
	endtask

	// Unwritten bytes read back a pattern of the full address
	function automatic loader_pkg::mem_byte_t mem_read(input loader_pkg::mem_addr_t addr);
		if (mem.exists(addr)) begin
			return mem[addr];
		end
		return addr[7:0] ^ addr[15:8] ^ addr[23:16] ^ {7'd0, addr[24]};
	endfunction

	function automatic int watchdog_cycles();
		int total;
		total = 0;
		foreach (STIM_TABLE[i]) begin
			total += int'(STIM_TABLE[i].len) + (STIM_TABLE[i].is_tap ? 0 : 2);
		end
		return total * 40 + 2000;
	endfunction

	// ======================================================================
	// Memory model and tape sink
	// ======================================================================
	initial begin : memory_model
		int delay;
		mem_ack   = 1'b0;
		mem_rdata = '0;
		forever begin
			@(negedge clk_sys);
			if (mem_req && !mem_ack) begin
				delay = $urandom_range(6, 1);
				repeat (delay) @(negedge clk_sys);
				if (mem_bus.we) begin
					mem[mem_bus.addr] = mem_bus.data;
					wr_log.push_back(mem_bus);
				end else begin
					mem_rdata = mem_read(mem_bus.addr);
				end
				mem_ack = 1'b1;
				do @(negedge clk_sys); while (mem_req);
				mem_ack = 1'b0;
			end
		end
	end

	initial begin : tape_sink
		int delay;
		tape_ack = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (tape_req && !tape_ack) begin
				got_tape.push_back(tape_byte);
				delay = $urandom_range(8, 1);
				repeat (delay) @(negedge clk_sys);
				tape_ack = 1'b1;
				do @(negedge clk_sys); while (tape_req);
				tape_ack = 1'b0;
			end
		end
	end

	initial begin : watchdog
		repeat (watchdog_cycles()) @(posedge clk_sys);
		$display("Error: run did not finish within %0d cycles", watchdog_cycles());
		$display("Result: FAILED");
		$finish;
	end

	// ======================================================================
	// Stimulus
	// ======================================================================
	task automatic build_file(input int i);
		loader_pkg::mem_addr_t base;
		loader_pkg::mem_req_t  req;
		loader_pkg::mem_byte_t b;

		file_bytes.delete();
		exp_wr.delete();
		base = loader_pkg::mem_addr_t'({STIM_TABLE[i].addr_hi, STIM_TABLE[i].addr_lo});
		// PRG files open with the little-endian load address
		if (!STIM_TABLE[i].is_tap) begin
			file_bytes.push_back(STIM_TABLE[i].addr_lo);
			file_bytes.push_back(STIM_TABLE[i].addr_hi);
		end
		for (int k = 0; k < int'(STIM_TABLE[i].len); k++) begin
			b = loader_pkg::mem_byte_t'($urandom_range(255, 0));
			file_bytes.push_back(b);
			req.we   = 1'b1;
			req.data = b;
			if (STIM_TABLE[i].is_tap) begin
				req.addr = `LDR_TAP_BASE + loader_pkg::mem_addr_t'(k);
				exp_tape.push_back(b);
			end else begin
				req.addr = base + loader_pkg::mem_addr_t'(k);
			end
			exp_wr.push_back(req);
			exp_mem[req.addr] = b;
		end
	endtask

	task automatic send_file(input logic is_tap);
		dl_index  = is_tap ? `LDR_IDX_TAP : `LDR_IDX_PRG;
		dl_active = 1'b1;
		repeat (2) @(negedge clk_sys);
		foreach (file_bytes[k]) begin
			while (dl_wait) @(negedge clk_sys);
			dl_addr = loader_pkg::mem_addr_t'(k);
			dl_data = file_bytes[k];
			dl_wr   = 1'b1;
			@(negedge clk_sys);
			dl_wr = 1'b0;
			@(negedge clk_sys);
		end
		while (dl_wait) @(negedge clk_sys);
		dl_active = 1'b0;
		// Index stays valid while the decoder sees the falling edge
		repeat (3) @(negedge clk_sys);
		dl_index = '0;
	endtask

	task automatic compare_writes(input int load);
		if (wr_log.size() != exp_wr.size()) begin
			errors++;
			$display("Error: load %0d issued %0d memory writes, expected %0d",
				load, wr_log.size(), exp_wr.size());
		end
		foreach (exp_wr[k]) begin
			if (k < wr_log.size()) begin
				check_addr("mem_o.addr", wr_log[k].addr, exp_wr[k].addr);
				check_byte("mem_o.data", wr_log[k].data, exp_wr[k].data);
			end
		end
	endtask

	task automatic press_play();
		play_btn = 1'b1;
		@(negedge clk_sys);
		play_btn = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic pause_and_resume(input int at);
		int n_press;
		int n_hold;

		while (got_tape.size() < at) @(negedge clk_sys);
		n_press = got_tape.size();
		press_play();
		// Give the handshake in flight time to close
		repeat (30) @(negedge clk_sys);
		if (got_tape.size() > n_press + 1) begin
			errors++;
			$display("Error: %0d tape bytes completed after pause, at most 1 allowed",
				got_tape.size() - n_press);
		end
		n_hold = got_tape.size();
		repeat (60) begin
			@(negedge clk_sys);
			check_flag("tape_req_o", tape_req, 1'b0);
		end
		if (got_tape.size() != n_hold) begin
			errors++;
			$display("Error: tape stream kept running while paused");
		end
		press_play();
	endtask

	task automatic compare_tape();
		if (got_tape.size() != exp_tape.size()) begin
			errors++;
			$display("Error: tape stream delivered %0d bytes, expected %0d",
				got_tape.size(), exp_tape.size());
		end
		foreach (exp_tape[k]) begin
			if (k < got_tape.size()) begin
				check_byte("tape_byte_o", got_tape[k], exp_tape[k]);
			end
		end
	endtask

	task automatic compare_memory();
		if (mem.num() != exp_mem.num()) begin
			errors++;
			$display("Error: memory holds %0d written bytes, expected %0d",
				mem.num(), exp_mem.num());
		end
		foreach (exp_mem[a]) begin
			if (!mem.exists(a)) begin
				errors++;
				$display("Error: no write reached address %h", a);
			end else begin
				check_byte($sformatf("mem[%h]", a), mem[a], exp_mem[a]);
			end
		end
	endtask

	initial begin : main_flow
		int unsigned total_fail;
		int          done_wait;

		reset_n   = 1'b0;
		dl_active = 1'b0;
		dl_index  = '0;
		dl_addr   = '0;
		dl_data   = '0;
		dl_wr     = 1'b0;
		play_btn  = 1'b0;
		void'($urandom(32'ha5dd1241));

		repeat (10) @(negedge clk_sys);
		reset_n = 1'b1;
		@(negedge clk_sys);
		check_flag("mem_req_o", mem_req, 1'b0);
		check_flag("tape_req_o", tape_req, 1'b0);
		check_flag("dl_wait_o", dl_wait, 1'b0);
		check_flag("tape_done_o", tape_done, 1'b0);

		// Later PRG loads overlap the tape playback started by the TAP entry
		for (int i = 0; i < NUM_LOADS; i++) begin
			build_file(i);
			wr_log.delete();
			send_file(STIM_TABLE[i].is_tap);
			compare_writes(i);
			if (STIM_TABLE[i].pause_at != 0) begin
				pause_and_resume(int'(STIM_TABLE[i].pause_at));
			end
		end

		// Done stays low while tape bytes are still to be offered
		while (got_tape.size() < exp_tape.size()) begin
			check_flag("tape_done_o", tape_done, 1'b0);
			@(negedge clk_sys);
		end
		// Last handshake closes within the sink delay and a few cycles
		done_wait = 0;
		while (!tape_done && (done_wait < 40)) begin
			@(negedge clk_sys);
			done_wait++;
		end
		check_flag("tape_done_o", tape_done, 1'b1);
		compare_tape();
		compare_memory();

		total_fail = errors + dut.props.fail_cnt;
		$display("Checks: %0d, errors: %0d, assertion failures: %0d",
			checks, errors, dut.props.fail_cnt);
		if (total_fail == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
